//--- dot_matrix_defs.svh
`ifndef DOT_MATRIX_DEFS_SVH
`define DOT_MATRIX_DEFS_SVH

// Panel geometry

// Rows per panel, scanned top to bottom
`define DM_ROWS 8

// Columns per panel, one bit per LED
`define DM_COLS 8

// Row counter width, enough for DM_ROWS
`define DM_ROW_BITS 3

// Digit range

// Width of one digit input
`define DM_DIGIT_BITS 4

// Largest value with a numeral glyph
`define DM_MAX_DIGIT 9

`endif

//--- dot_matrix_pkg.sv
`default_nettype none

`include "dot_matrix_defs.svh"

package dot_matrix_pkg;

    // Row being scanned, 0 is the top row
    typedef logic [`DM_ROW_BITS-1:0] row_idx_t;

    // Active-low row select, one zero bit per scanned row
    typedef logic [`DM_ROWS-1:0] row_sel_t;

    // Column pattern, a set bit lights the LED
    typedef logic [`DM_COLS-1:0] col_t;

    // Number shown on one panel
    typedef logic [`DM_DIGIT_BITS-1:0] digit_t;

endpackage

`default_nettype wire

//--- row_scan.sv
`timescale 1ns/1ps
`default_nettype none

`include "dot_matrix_defs.svh"

module row_scan
    import dot_matrix_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     reset,
    output row_idx_t      row_idx,
    output row_sel_t      dot_row
);

    row_idx_t row_count;
    row_sel_t row_sel_next;

    // Panels look up the same row the select is built from
    assign row_idx = row_count;

    // Row 0 drives the MSB low, row 7 the LSB
    always_comb begin
        case (row_count)
            3'd0: row_sel_next = 8'b01111111;
            3'd1: row_sel_next = 8'b10111111;
            3'd2: row_sel_next = 8'b11011111;
            3'd3: row_sel_next = 8'b11101111;
            3'd4: row_sel_next = 8'b11110111;
            3'd5: row_sel_next = 8'b11111011;
            3'd6: row_sel_next = 8'b11111101;
            3'd7: row_sel_next = 8'b11111110;
            default: row_sel_next = '1;
        endcase
    end

    // Free-running scan, wraps from the last row back to the top
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            row_count <= '0;
            dot_row   <= '0;
        end else begin
            dot_row   <= row_sel_next;
            row_count <= row_count + `DM_ROW_BITS'(1);
        end
    end

endmodule

`default_nettype wire

//--- digit_panel.sv
`timescale 1ns/1ps
`default_nettype none

`include "dot_matrix_defs.svh"

module digit_panel
    import dot_matrix_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire row_idx_t row_idx,
    input  wire digit_t   digit,
    output col_t          col
);

    logic is_numeral;
    col_t glyph_next;

    // Numeral glyphs, 0 through 9
    function automatic col_t numeral_row(input digit_t d, input row_idx_t r);
        col_t pattern;
        pattern = '0;
        case (d)
            4'd0: begin
                case (r)
                    3'd0, 3'd7: pattern = 8'b01111110;
                    default:    pattern = 8'b01000010;
                endcase
            end
            4'd1: begin
                pattern = 8'b00001000;
            end
            4'd2: begin
                case (r)
                    3'd0: pattern = 8'b01111110;
                    3'd1: pattern = 8'b00000010;
                    3'd2: pattern = 8'b00000010;
                    3'd3: pattern = 8'b00000010;
                    3'd4: pattern = 8'b01111110;
                    3'd5: pattern = 8'b01000000;
                    3'd6: pattern = 8'b01000000;
                    3'd7: pattern = 8'b01111110;
                endcase
            end
            4'd3: begin
                case (r)
                    3'd0: pattern = 8'b01111110;
                    3'd1: pattern = 8'b00000010;
                    3'd2: pattern = 8'b00000010;
                    3'd3: pattern = 8'b00000010;
                    3'd4: pattern = 8'b01111110;
                    3'd5: pattern = 8'b00000010;
                    3'd6: pattern = 8'b00000010;
                    3'd7: pattern = 8'b01111110;
                endcase
            end
            4'd4: begin
                case (r)
                    3'd0: pattern = 8'b01000010;
                    3'd1: pattern = 8'b01000010;
                    3'd2: pattern = 8'b01000010;
                    3'd3: pattern = 8'b01000010;
                    3'd4: pattern = 8'b01111110;
                    3'd5: pattern = 8'b00000010;
                    3'd6: pattern = 8'b00000010;
                    3'd7: pattern = 8'b00000010;
                endcase
            end
            4'd5: begin
                case (r)
                    3'd0: pattern = 8'b01111110;
                    3'd1: pattern = 8'b01000000;
                    3'd2: pattern = 8'b01000000;
                    3'd3: pattern = 8'b01000000;
                    3'd4: pattern = 8'b01111110;
                    3'd5: pattern = 8'b00000010;
                    3'd6: pattern = 8'b00000010;
                    3'd7: pattern = 8'b01111110;
                endcase
            end
            4'd6: begin
                case (r)
                    3'd0: pattern = 8'b01111110;
                    3'd1: pattern = 8'b01000000;
                    3'd2: pattern = 8'b01000000;
                    3'd3: pattern = 8'b01000000;
                    3'd4: pattern = 8'b01111110;
                    3'd5: pattern = 8'b01000010;
                    3'd6: pattern = 8'b01000010;
                    3'd7: pattern = 8'b01111110;
                endcase
            end
            4'd7: begin
                case (r)
                    3'd0: pattern = 8'b01111110;
                    3'd1: pattern = 8'b01000010;
                    3'd2: pattern = 8'b01000010;
                    3'd3: pattern = 8'b01000010;
                    default: pattern = 8'b00000010;
                endcase
            end
            4'd8: begin
                case (r)
                    3'd0: pattern = 8'b01111110;
                    3'd1: pattern = 8'b01000010;
                    3'd2: pattern = 8'b01000010;
                    3'd3: pattern = 8'b01000010;
                    3'd4: pattern = 8'b01111110;
                    3'd5: pattern = 8'b01000010;
                    3'd6: pattern = 8'b01000010;
                    3'd7: pattern = 8'b01111110;
                endcase
            end
            4'd9: begin
                case (r)
                    3'd0: pattern = 8'b01111110;
                    3'd1: pattern = 8'b01000010;
                    3'd2: pattern = 8'b01000010;
                    3'd3: pattern = 8'b01000010;
                    3'd4: pattern = 8'b01111110;
                    3'd5: pattern = 8'b00000010;
                    3'd6: pattern = 8'b00000010;
                    3'd7: pattern = 8'b01111110;
                endcase
            end
            default: begin
                pattern = '0;
            end
        endcase
        return pattern;
    endfunction

    // Question mark, shown for anything that is not a numeral
    function automatic col_t qmark_row(input row_idx_t r);
        col_t pattern;
        case (r)
            3'd0: pattern = 8'b00011000;
            3'd1: pattern = 8'b00100100;
            3'd2: pattern = 8'b01000010;
            3'd3: pattern = 8'b00000100;
            3'd4: pattern = 8'b00001000;
            3'd5: pattern = 8'b00001000;
            3'd6: pattern = 8'b00000000;
            3'd7: pattern = 8'b00001000;
            default: pattern = '0;
        endcase
        return pattern;
    endfunction

    assign is_numeral = (digit <= digit_t'(`DM_MAX_DIGIT));

    always_comb begin
        if (is_numeral) begin
            glyph_next = numeral_row(digit, row_idx);
        end else begin
            glyph_next = qmark_row(row_idx);
        end
    end

    // Same edge as the row select, so columns and row stay paired
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            col <= '0;
        end else begin
            col <= glyph_next;
        end
    end

endmodule

`default_nettype wire

//--- dot_matrix.sv
`timescale 1ns/1ps
`default_nettype none

module dot_matrix
    import dot_matrix_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire digit_t   digit1,
    input  wire digit_t   digit2,
    output row_sel_t      dot_row,
    output col_t          dot_col1,
    output col_t          dot_col2
);

    // Shared row index, both panels follow one scanner
    row_idx_t row_idx;

    row_scan u_row_scan (
        .clk     (clk),
        .reset   (reset),
        .row_idx (row_idx),
        .dot_row (dot_row)
    );

    // Left panel
    digit_panel u_panel1 (
        .clk     (clk),
        .reset   (reset),
        .row_idx (row_idx),
        .digit   (digit1),
        .col     (dot_col1)
    );

    // Right panel
    digit_panel u_panel2 (
        .clk     (clk),
        .reset   (reset),
        .row_idx (row_idx),
        .digit   (digit2),
        .col     (dot_col2)
    );

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS = 8
) (
    output logic clk
);

    // Free-running clock, starts low
    initial begin
        clk = 1'b0;
    end

    always #(PERIOD_NS / 2) clk = ~clk;

endmodule

`default_nettype wire

//--- tb_dot_matrix.sv
`timescale 1ns/1ps
`default_nettype none

`include "dot_matrix_defs.svh"

module tb_dot_matrix
    import dot_matrix_pkg::*;
();

    localparam int CLK_PERIOD  = 8;
    localparam int MAX_ENTRIES = 64;
    localparam int N_RANDOM    = 16;

    logic     clk;
    logic     reset;
    digit_t   digit1;
    digit_t   digit2;
    row_sel_t dot_row;
    col_t     dot_col1;
    col_t     dot_col2;

    // Stimulus table: digit per panel and cycles to hold
    digit_t tab_d1 [0:MAX_ENTRIES-1];
    digit_t tab_d2 [0:MAX_ENTRIES-1];
    int     tab_hold [0:MAX_ENTRIES-1];
    int     n_entries;
    int     total_cycles;
    logic   table_ready;

    int edge_count;
    int n_checks;
    int n_errors;

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD)) u_clock_gen (
        .clk (clk)
    );

    dot_matrix u_dut (
        .clk      (clk),
        .reset    (reset),
        .digit1   (digit1),
        .digit2   (digit2),
        .dot_row  (dot_row),
        .dot_col1 (dot_col1),
        .dot_col2 (dot_col2)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Glyphs packed with row 0 in the top byte
    function automatic logic [63:0] glyph_bits(input int idx);
        logic [63:0] g;
        case (idx)
            0:       g = 64'h7E42_4242_4242_427E;
            1:       g = 64'h0808_0808_0808_0808;
            2:       g = 64'h7E02_0202_7E40_407E;
            3:       g = 64'h7E02_0202_7E02_027E;
            4:       g = 64'h4242_4242_7E02_0202;
            5:       g = 64'h7E40_4040_7E02_027E;
            6:       g = 64'h7E40_4040_7E42_427E;
            7:       g = 64'h7E42_4242_0202_0202;
            8:       g = 64'h7E42_4242_7E42_427E;
            9:       g = 64'h7E42_4242_7E02_027E;
            default: g = 64'h1824_4204_0808_0008;
        endcase
        return g;
    endfunction

    function automatic logic [7:0] expected_col(input digit_t d, input int row);
        logic [63:0] g;
        int          idx;
        idx = (d > `DM_MAX_DIGIT) ? 10 : int'(d);
        g = glyph_bits(idx);
        return g[(63 - 8 * row) -: 8];
    endfunction

    task automatic check(input string name, input logic [7:0] actual,
                         input logic [7:0] expected);
        n_checks++;
        if (actual !== expected) begin
            n_errors++;
            $display("FAIL %s: got 0x%h expected 0x%h (time %0t)",
                     name, actual, expected, $time);
        end
    endtask

    task automatic check_outputs_dark();
        check("dot_row", dot_row, 8'h00);
        check("dot_col1", dot_col1, 8'h00);
        check("dot_col2", dot_col2, 8'h00);
    endtask

    task automatic add_entry(input digit_t d1, input digit_t d2, input int hold);
        tab_d1[n_entries]   = d1;
        tab_d2[n_entries]   = d2;
        tab_hold[n_entries] = hold;
        total_cycles += hold;
        n_entries++;
    endtask

    task automatic build_table();
        logic [31:0] rng;
        int          i;
        rng = 32'h56a2_18ac;
        // Every numeral for a full scan, different on each panel
        for (i = 0; i <= 9; i++) begin
            add_entry(digit_t'(i), digit_t'(9 - i), `DM_ROWS);
        end
        // Out-of-range values on both panels
        for (i = 10; i <= 15; i++) begin
            add_entry(digit_t'(i), digit_t'(25 - i), `DM_ROWS);
        end
        // Changes in the middle of a scan
        add_entry(4'd3, 4'd7, 3);
        add_entry(4'd6, 4'd2, 5);
        add_entry(4'd9, 4'd12, 2);
        add_entry(4'd0, 4'd1, 1);
        add_entry(4'd15, 4'd4, 7);
        for (i = 0; i < N_RANDOM; i++) begin
            rng = xorshift32(rng);
            add_entry(digit_t'(rng[3:0]), digit_t'(rng[7:4]), 1 + int'(rng[11:8]));
        end
    endtask

    // Watchdog sized from the stimulus table
    initial begin
        wait (table_ready === 1'b1);
        #((total_cycles + 20) * CLK_PERIOD);
        $display("Timeout: the scan did not finish in the expected time");
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        int idx;
        int cyc;
        int row;
        reset        = 1'b0;
        digit1       = '0;
        digit2       = '0;
        n_entries    = 0;
        total_cycles = 0;
        edge_count   = 0;
        n_checks     = 0;
        n_errors     = 0;
        table_ready  = 1'b0;
        build_table();
        table_ready = 1'b1;

        repeat (2) begin
            @(posedge clk);
            #1;
            check_outputs_dark();
        end
        reset = 1'b1;
        // Still dark until the first edge after release
        check_outputs_dark();

        for (idx = 0; idx < n_entries; idx++) begin
            digit1 = tab_d1[idx];
            digit2 = tab_d2[idx];
            for (cyc = 0; cyc < tab_hold[idx]; cyc++) begin
                @(posedge clk);
                #1;
                edge_count++;
                row = (edge_count - 1) % `DM_ROWS;
                check("dot_row", dot_row, ~(8'h80 >> row));
                check("dot_col1", dot_col1, expected_col(tab_d1[idx], row));
                check("dot_col2", dot_col2, expected_col(tab_d2[idx], row));
            end
        end

        $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dot_matrix.f
+incdir+.
dot_matrix_pkg.sv
row_scan.sv
digit_panel.sv
dot_matrix.sv
tb_clock_gen.sv
tb_dot_matrix.sv
